// ==== all.f ====
+incdir+design
design/wb_pkg.sv
design/fetch_pkg.sv
design/thread_ctx.sv
design/instr_scan.sv
design/bht.sv
design/fetch_queue.sv
design/fetch_frontend.sv
test/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the fetch frontend testbench with Verilator
# call from the project root

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_frontend -f all.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "^TESTS PASSED$" "$log"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $log"
  exit 1
fi

// ==== test/tb_fetch_frontend.sv ====
// testbench for the two-thread fetch frontend
// each stimulus row is one expected entry of one thread, plus an optional
// backend action that is driven in the cycle after that row leaves the DUT
// the memory answers in 0 to 3 cycles and answers with err on fault rows
// entries of a thread beyond its last row are accepted but not checked
`include "fetch_macros.svh"

module tb_fetch_frontend;

  localparam logic [31:0] boot_addr  = 32'h0000_1000;
  localparam int          max_cycles = 5000;
  localparam int          bus_checks = 6;

  // instruction words used by the programs
  localparam logic [31:0] nop     = 32'h0000_0013;
  localparam logic [31:0] jal_p8  = 32'h0080_006f;
  localparam logic [31:0] jal_m8  = 32'hff9f_f06f;
  localparam logic [31:0] beq_p8  = 32'h0000_0463;
  localparam logic [31:0] beq_m4  = 32'hfe00_0ee3;
  localparam logic [31:0] jalr_ra = 32'h0000_8067;

  localparam logic [1:0] act_none    = 2'd0;
  localparam logic [1:0] act_resolve = 2'd1;
  localparam logic [1:0] act_trap    = 2'd2;
  localparam logic [1:0] act_ret     = 2'd3;

  typedef struct packed {
    fetch_pkg::fetch_entry_t exp;
    logic [1:0]              act;
    logic                    act_taken;
    logic                    act_misp;
    logic [31:0]             act_target;
  } row_t;

  logic                    clk;
  logic                    rst_ni;
  wb_pkg::wb_req_t         wb_req;
  wb_pkg::wb_rsp_t         wb_rsp;
  fetch_pkg::resolve_t     resolve;
  fetch_pkg::redirect_t    redirect;
  fetch_pkg::fetch_entry_t entry;
  logic                    entry_valid;
  logic                    entry_ready;

  row_t        rows [$];
  int          exp_q0 [$];
  int          exp_q1 [$];
  logic [31:0] mem_words [logic [31:0]];
  logic        mem_err [logic [31:0]];
  logic [31:0] lcg_state;

  fetch_frontend i_dut (
    .clk_i         (clk),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr),
    .wb_o          (wb_req),
    .wb_i          (wb_rsp),
    .resolve_i     (resolve),
    .redirect_i    (redirect),
    .entry_o       (entry),
    .entry_valid_o (entry_valid),
    .entry_ready_i (entry_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // untouched words are addi, the immediate mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return {adr[31:7] ^ adr[24:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    if (mem_words.exists(adr)) begin
      return mem_words[adr];
    end
    return fill_word(adr);
  endfunction

  task automatic add_row(input logic [`FE_TID_W-1:0] tid, input logic [31:0] pc,
                         input logic [31:0] instr, input fetch_pkg::cf_e cf,
                         input logic taken, input logic [31:0] target, input logic fault);
    row_t r;
    r                      = '0;
    r.exp.pc               = pc;
    r.exp.instr            = instr;
    r.exp.thread_id        = tid;
    r.exp.cf               = cf;
    r.exp.predict_taken    = taken;
    r.exp.predict_target   = target;
    r.exp.fault            = fault;
    r.act                  = act_none;
    rows.push_back(r);
    mem_words[pc] = instr;
    mem_err[pc]   = fault;
  endtask

  // attaches a backend action to the last row
  task automatic add_action(input logic [1:0] act, input logic taken, input logic misp,
                            input logic [31:0] target);
    row_t r;
    r            = rows.pop_back();
    r.act        = act;
    r.act_taken  = taken;
    r.act_misp   = misp;
    r.act_target = target;
    rows.push_back(r);
  endtask

  task automatic apply_action(input row_t r);
    if (r.act == act_resolve) begin
      resolve.valid      = 1'b1;
      resolve.thread_id  = r.exp.thread_id;
      resolve.pc         = r.exp.pc;
      resolve.is_branch  = 1'b1;
      resolve.taken      = r.act_taken;
      resolve.mispredict = r.act_misp;
      resolve.target     = r.act_target;
    end else if (r.act != act_none) begin
      redirect.valid     = 1'b1;
      redirect.kind      = (r.act == act_trap) ? fetch_pkg::RedirTrap : fetch_pkg::RedirRet;
      redirect.thread_id = r.exp.thread_id;
      redirect.target    = r.act_target;
    end
  endtask

  // --------------------
  // checks
  // --------------------
  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_entry(input fetch_pkg::fetch_entry_t got,
                             input fetch_pkg::fetch_entry_t exp, input int row);
    if (got !== exp) begin
      $display("Fail at %0t: row %0d, fetch entry differs", $time, row);
      $display("  got pc %h instr %h tid %0d cf %0d taken %b target %h fault %b",
               got.pc, got.instr, got.thread_id, got.cf, got.predict_taken,
               got.predict_target, got.fault);
      $display("  exp pc %h instr %h tid %0d cf %0d taken %b target %h fault %b",
               exp.pc, exp.instr, exp.thread_id, exp.cf, exp.predict_taken,
               exp.predict_target, exp.fault);
      stop_run();
    end
  endtask

  // address is only compared while a cycle is expected
  task automatic check_bus(input wb_pkg::wb_req_t got, input wb_pkg::wb_req_t exp);
    if (got.cyc !== exp.cyc || got.stb !== exp.stb || (exp.cyc && got.adr !== exp.adr)) begin
      $display("Fail at %0t: bus request cyc %b stb %b adr %h, expected cyc %b stb %b adr %h",
               $time, got.cyc, got.stb, got.adr, exp.cyc, exp.stb, exp.adr);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic build_table();
    // thread 0: JAL, static forward and backward branches, then history training
    add_row(1'b0, 32'h1000, nop, fetch_pkg::NoCF, 1'b0, 32'h1004, 1'b0);
    add_row(1'b0, 32'h1004, nop, fetch_pkg::NoCF, 1'b0, 32'h1008, 1'b0);
    add_row(1'b0, 32'h1008, jal_p8, fetch_pkg::Jump, 1'b1, 32'h1010, 1'b0);
    add_row(1'b0, 32'h1010, nop, fetch_pkg::NoCF, 1'b0, 32'h1014, 1'b0);
    add_row(1'b0, 32'h1014, beq_p8, fetch_pkg::Branch, 1'b0, 32'h1018, 1'b0);
    add_row(1'b0, 32'h1018, nop, fetch_pkg::NoCF, 1'b0, 32'h101c, 1'b0);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    add_row(1'b0, 32'h1020, beq_m4, fetch_pkg::Branch, 1'b1, 32'h101c, 1'b0);
    add_action(act_resolve, 1'b0, 1'b1, 32'h1024);
    add_row(1'b0, 32'h1024, jal_m8, fetch_pkg::Jump, 1'b1, 32'h101c, 1'b0);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    add_row(1'b0, 32'h1020, beq_m4, fetch_pkg::Branch, 1'b0, 32'h1024, 1'b0);
    // correct not-taken outcome, the counter reaches 0
    add_action(act_resolve, 1'b0, 1'b0, 32'h1024);
    add_row(1'b0, 32'h1024, jal_m8, fetch_pkg::Jump, 1'b1, 32'h101c, 1'b0);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    add_row(1'b0, 32'h1020, beq_m4, fetch_pkg::Branch, 1'b0, 32'h1024, 1'b0);
    add_action(act_resolve, 1'b1, 1'b1, 32'h101c);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    add_row(1'b0, 32'h1020, beq_m4, fetch_pkg::Branch, 1'b0, 32'h1024, 1'b0);
    add_action(act_resolve, 1'b1, 1'b1, 32'h101c);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    add_row(1'b0, 32'h1020, beq_m4, fetch_pkg::Branch, 1'b1, 32'h101c, 1'b0);
    add_row(1'b0, 32'h101c, nop, fetch_pkg::NoCF, 1'b0, 32'h1020, 1'b0);
    // thread 1: bus error, trap, JALR and exception return
    add_row(1'b1, 32'h1100, nop, fetch_pkg::NoCF, 1'b0, 32'h1104, 1'b0);
    add_row(1'b1, 32'h1104, nop, fetch_pkg::NoCF, 1'b0, 32'h1108, 1'b0);
    add_row(1'b1, 32'h1108, jal_p8, fetch_pkg::NoCF, 1'b0, 32'h110c, 1'b1);
    add_row(1'b1, 32'h110c, nop, fetch_pkg::NoCF, 1'b0, 32'h1110, 1'b0);
    add_row(1'b1, 32'h1110, nop, fetch_pkg::NoCF, 1'b0, 32'h1114, 1'b0);
    add_action(act_trap, 1'b0, 1'b0, 32'h1180);
    add_row(1'b1, 32'h1180, nop, fetch_pkg::NoCF, 1'b0, 32'h1184, 1'b0);
    add_row(1'b1, 32'h1184, jalr_ra, fetch_pkg::JumpR, 1'b0, 32'h1188, 1'b0);
    add_row(1'b1, 32'h1188, nop, fetch_pkg::NoCF, 1'b0, 32'h118c, 1'b0);
    add_action(act_ret, 1'b0, 1'b0, 32'h1100);
    add_row(1'b1, 32'h1100, nop, fetch_pkg::NoCF, 1'b0, 32'h1104, 1'b0);
    add_row(1'b1, 32'h1104, nop, fetch_pkg::NoCF, 1'b0, 32'h1108, 1'b0);
  endtask

  // --------------------
  // stimulus and scoreboard
  // --------------------
  initial begin
    int              cycles;
    int              bus_count;
    int              pending;
    int              row_idx;
    logic            bus_active;
    logic [1:0]      bus_wait;
    wb_pkg::wb_req_t exp_req;

    rst_ni      = 1'b0;
    wb_rsp      = '0;
    resolve     = '0;
    redirect    = '0;
    entry_ready = 1'b0;
    lcg_state   = 32'h3612_0fd9;
    exp_req     = '0;
    build_table();
    foreach (rows[i]) begin
      if (rows[i].exp.thread_id == 1'b0) begin
        exp_q0.push_back(i);
      end else begin
        exp_q1.push_back(i);
      end
    end

    repeat (4) begin
      @(posedge clk);
      #1;
      check_bus(wb_req, exp_req);
      check_flag(entry_valid, 1'b0, "entry_valid_o during reset");
    end
    rst_ni = 1'b1;

    cycles     = 0;
    bus_count  = 0;
    pending    = -1;
    bus_active = 1'b0;
    bus_wait   = 2'd0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < max_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
      resolve  = '0;
      redirect = '0;
      if (pending >= 0) begin
        apply_action(rows[pending]);
        pending = -1;
      end

      // memory slave, one word per cycle of cyc
      wb_rsp = '0;
      if (wb_req.cyc && wb_req.stb) begin
        if (!bus_active) begin
          bus_active = 1'b1;
          lcg_state  = lcg_next(lcg_state);
          bus_wait   = lcg_state[17:16];
          // early transfers alternate between the boot streams
          if (bus_count < bus_checks) begin
            exp_req.cyc = 1'b1;
            exp_req.stb = 1'b1;
            exp_req.adr = boot_addr + 32'(bus_count % 2) * `FE_THREAD_STRIDE
                          + 32'(bus_count / 2) * 32'd4;
            check_bus(wb_req, exp_req);
          end
          bus_count++;
        end
        if (bus_wait == 2'd0) begin
          wb_rsp.dat = read_word(wb_req.adr);
          if (mem_err.exists(wb_req.adr) && mem_err[wb_req.adr]) begin
            wb_rsp.err = 1'b1;
          end else begin
            wb_rsp.ack = 1'b1;
          end
          bus_active = 1'b0;
        end else begin
          bus_wait = bus_wait - 2'd1;
        end
      end

      lcg_state   = lcg_next(lcg_state);
      entry_ready = (lcg_state[19:18] != 2'b00);

      #2;
      if (entry_valid && entry_ready) begin
        row_idx = -1;
        if (entry.thread_id == 1'b0 && exp_q0.size() != 0) begin
          row_idx = exp_q0.pop_front();
        end else if (entry.thread_id == 1'b1 && exp_q1.size() != 0) begin
          row_idx = exp_q1.pop_front();
        end
        if (row_idx >= 0) begin
          check_entry(entry, rows[row_idx].exp, row_idx);
          if (rows[row_idx].act != act_none) begin
            pending = row_idx;
          end
        end
      end
    end

    if (exp_q0.size() == 0 && exp_q1.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("timeout: %0d entries of thread 0 and %0d of thread 1 never arrived",
               exp_q0.size(), exp_q1.size());
      stop_run();
    end
  end

endmodule

// ==== design/fetch_frontend.sv ====
// two-thread RV32 fetch frontend with a Wishbone classic master port
// one word per transfer, one transfer outstanding, no compressed code
// JAL and branches are predicted at fetch, JALR falls through
// a redirect in the cycle of an acknowledge drops that word, its thread
// refetches it later, so no entry is lost or repeated
`include "fetch_macros.svh"

module fetch_frontend (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`FE_XLEN-1:0]     boot_addr_i,
  // instruction bus
  output wb_pkg::wb_req_t         wb_o,
  input  wb_pkg::wb_rsp_t         wb_i,
  // backend control
  input  fetch_pkg::resolve_t     resolve_i,
  input  fetch_pkg::redirect_t    redirect_i,
  // decode handshake
  output fetch_pkg::fetch_entry_t entry_o,
  output logic                    entry_valid_o,
  input  logic                    entry_ready_i
);

  logic                    busy_q;
  logic                    discard_q;
  logic [`FE_TID_W-1:0]    busy_tid_q;
  logic [`FE_XLEN-1:0]     adr_q;
  logic                    start;
  logic                    done;
  logic                    accept;

  logic                    mispredict;
  logic                    redir_valid;
  logic [`FE_TID_W-1:0]    redir_tid;
  logic [`FE_XLEN-1:0]     redir_pc;

  logic [`FE_TID_W-1:0]    cur_tid;
  logic [`FE_XLEN-1:0]     cur_pc;
  logic                    pc_write;
  logic [`FE_TID_W-1:0]    pc_write_tid;
  logic [`FE_XLEN-1:0]     pc_write_val;

  fetch_pkg::scan_t        scan;
  fetch_pkg::bht_update_t  bht_update;
  logic                    bht_valid;
  logic                    bht_taken;
  logic                    branch_taken;
  logic [`FE_XLEN-1:0]     seq_pc;
  fetch_pkg::fetch_entry_t new_entry;
  logic                    q_space;

  // --------------------
  // redirects
  // --------------------
  // a mispredict wins over a trap or an exception return
  assign mispredict  = resolve_i.valid && resolve_i.mispredict;
  assign redir_valid = mispredict || redirect_i.valid;
  assign redir_tid   = mispredict ? resolve_i.thread_id : redirect_i.thread_id;
  assign redir_pc    = mispredict ? resolve_i.target : redirect_i.target;

  // --------------------
  // bus master
  // --------------------
  assign start  = !busy_q && q_space;
  assign done   = busy_q && (wb_i.ack || wb_i.err);
  assign accept = done && !discard_q && !redir_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      discard_q  <= 1'b0;
      busy_tid_q <= '0;
    end else if (start) begin
      busy_q     <= 1'b1;
      busy_tid_q <= cur_tid;
      discard_q  <= redir_valid && (redir_tid == cur_tid);
    end else if (done) begin
      busy_q    <= 1'b0;
      discard_q <= 1'b0;
    end else if (busy_q && redir_valid && redir_tid == busy_tid_q) begin
      discard_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= cur_pc;
    end
  end

  assign wb_o.cyc = busy_q;
  assign wb_o.stb = busy_q;
  assign wb_o.adr = adr_q;

  // --------------------
  // prediction
  // --------------------
  assign seq_pc       = adr_q + `FE_XLEN'(4);
  // static fallback: backward taken, forward not taken
  assign branch_taken = bht_valid ? bht_taken : scan.imm[`FE_XLEN-1];

  always_comb begin
    new_entry.pc             = adr_q;
    new_entry.instr          = wb_i.dat;
    new_entry.thread_id      = busy_tid_q;
    new_entry.fault          = wb_i.err;
    new_entry.cf             = fetch_pkg::NoCF;
    new_entry.predict_taken  = 1'b0;
    new_entry.predict_target = seq_pc;
    if (!wb_i.err) begin
      if (scan.is_jal) begin
        new_entry.cf             = fetch_pkg::Jump;
        new_entry.predict_taken  = 1'b1;
        new_entry.predict_target = adr_q + scan.imm;
      end else if (scan.is_branch) begin
        new_entry.cf            = fetch_pkg::Branch;
        new_entry.predict_taken = branch_taken;
        if (branch_taken) begin
          new_entry.predict_target = adr_q + scan.imm;
        end
      end else if (scan.is_jalr) begin
        new_entry.cf = fetch_pkg::JumpR;
      end
    end
  end

  assign bht_update.valid = resolve_i.valid && resolve_i.is_branch;
  assign bht_update.pc    = resolve_i.pc;
  assign bht_update.taken = resolve_i.taken;

  // --------------------
  // next PC
  // --------------------
  assign pc_write     = redir_valid || accept;
  assign pc_write_tid = redir_valid ? redir_tid : busy_tid_q;
  assign pc_write_val = redir_valid ? redir_pc : new_entry.predict_target;

  thread_ctx i_thread_ctx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .boot_addr_i (boot_addr_i),
    .write_i     (pc_write),
    .write_tid_i (pc_write_tid),
    .write_pc_i  (pc_write_val),
    .advance_i   (done),
    .cur_tid_o   (cur_tid),
    .cur_pc_o    (cur_pc)
  );

  instr_scan i_instr_scan (
    .instr_i (wb_i.dat),
    .scan_o  (scan)
  );

  bht i_bht (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .pc_i     (adr_q),
    .update_i (bht_update),
    .valid_o  (bht_valid),
    .taken_o  (bht_taken)
  );

  fetch_queue i_fetch_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (accept),
    .entry_i    (new_entry),
    .kill_i     (redir_valid),
    .kill_tid_i (redir_tid),
    .space_o    (q_space),
    .entry_o    (entry_o),
    .valid_o    (entry_valid_o),
    .ready_i    (entry_ready_i)
  );

  // classic cycle ends only on a slave termination
  a_cyc_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(wb_o.cyc) |-> $past(wb_i.ack || wb_i.err));

endmodule

// ==== design/fetch_queue.sv ====
// circular fetch queue towards decode
// a kill clears the live bit of every slot of one thread; dead heads are
// popped one per cycle with valid_o low, so space returns gradually
// a head hit by a kill in the current cycle is already hidden
`include "fetch_macros.svh"

module fetch_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t entry_i,
  input  logic                    kill_i,
  input  logic [`FE_TID_W-1:0]    kill_tid_i,
  output logic                    space_o,
  output fetch_pkg::fetch_entry_t entry_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  localparam int unsigned          depth    = `FE_QUEUE_DEPTH;
  localparam int unsigned          ptr_w    = $clog2(depth);
  localparam logic [ptr_w-1:0]     last_idx = ptr_w'(depth - 1);
  localparam logic [ptr_w:0]       full_cnt = (ptr_w + 1)'(depth);

  fetch_pkg::fetch_entry_t mem_q [depth];
  logic [depth-1:0]        live_q;
  logic [ptr_w-1:0]        rd_ptr_q;
  logic [ptr_w-1:0]        wr_ptr_q;
  logic [ptr_w:0]          count_q;
  logic                    empty;
  logic                    head_kill;
  logic                    pop;

  assign empty     = (count_q == '0);
  assign entry_o   = mem_q[rd_ptr_q];
  assign head_kill = kill_i && (entry_o.thread_id == kill_tid_i);
  assign valid_o   = !empty && live_q[rd_ptr_q] && !head_kill;
  assign space_o   = (count_q < full_cnt);

  // handshake pop or silent drop of a dead head
  assign pop = (valid_o && ready_i) || (!empty && !live_q[rd_ptr_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q   <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (kill_i) begin
        for (int i = 0; i < depth; i++) begin
          if (mem_q[i].thread_id == kill_tid_i) begin
            live_q[i] <= 1'b0;
          end
        end
      end
      if (pop) begin
        live_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q         <= (rd_ptr_q == last_idx) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i) begin
        live_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q         <= (wr_ptr_q == last_idx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // the fetch side reserves a slot before it starts a bus transfer
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> space_o);

  // an offered entry holds until decode takes it
  a_entry_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> $stable(entry_o));

endmodule

// ==== design/bht.sv ====
// branch history table of 2-bit saturating counters
// direct mapped on PC bits above the word offset, no tags,
// so aliasing branches share one counter
// read is combinational, an update is seen on the next cycle
`include "fetch_macros.svh"

module bht (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FE_XLEN-1:0]    pc_i,
  input  fetch_pkg::bht_update_t update_i,
  output logic                   valid_o,
  output logic                   taken_o
);

  localparam int unsigned idx_w = $clog2(`FE_BHT_ENTRIES);

  logic [1:0]                 cnt_q [`FE_BHT_ENTRIES];
  logic [`FE_BHT_ENTRIES-1:0] valid_q;
  logic [idx_w-1:0]           rd_idx;
  logic [idx_w-1:0]           up_idx;

  assign rd_idx = pc_i[idx_w+1:2];
  assign up_idx = update_i.pc[idx_w+1:2];

  // --------------------
  // lookup
  // --------------------
  assign valid_o = valid_q[rd_idx];
  assign taken_o = cnt_q[rd_idx][1];

  // --------------------
  // training
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      if (!valid_q[up_idx]) begin
        // first outcome seeds a weak state in its direction
        cnt_q[up_idx] <= update_i.taken ? 2'd2 : 2'd1;
      end else if (update_i.taken && cnt_q[up_idx] != 2'd3) begin
        cnt_q[up_idx] <= cnt_q[up_idx] + 2'd1;
      end else if (!update_i.taken && cnt_q[up_idx] != 2'd0) begin
        cnt_q[up_idx] <= cnt_q[up_idx] - 2'd1;
      end
    end
  end

endmodule

// ==== design/instr_scan.sv ====
// control-flow decode of one uncompressed RV32 word
// imm is the J-type offset for JAL and the B-type offset otherwise,
// so it is only meaningful for JAL and conditional branches
`include "fetch_macros.svh"

module instr_scan (
  input  logic [`FE_XLEN-1:0] instr_i,
  output fetch_pkg::scan_t    scan_o
);

  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;

  logic [6:0]          opcode;
  logic [`FE_XLEN-1:0] b_imm;
  logic [`FE_XLEN-1:0] j_imm;

  assign opcode = instr_i[6:0];

  // --------------------
  // immediates
  // --------------------
  // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign b_imm = {{(`FE_XLEN - 12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // J-type: imm[20|10:1|11|19:12] in 31:12
  assign j_imm = {{(`FE_XLEN - 20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    scan_o.is_branch = (opcode == opc_branch);
    scan_o.is_jal    = (opcode == opc_jal);
    scan_o.is_jalr   = (opcode == opc_jalr);
    scan_o.imm       = scan_o.is_jal ? j_imm : b_imm;
  end

endmodule

// ==== design/thread_ctx.sv ====
// per-thread program counters with a round-robin pointer
// the PCs load from boot_addr_i on the first clock after reset,
// during that cycle cur_pc_o already shows the boot value
// a write in the load cycle wins over the boot value for its thread
`include "fetch_macros.svh"

module thread_ctx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`FE_XLEN-1:0]  boot_addr_i,
  input  logic                 write_i,
  input  logic [`FE_TID_W-1:0] write_tid_i,
  input  logic [`FE_XLEN-1:0]  write_pc_i,
  input  logic                 advance_i,
  output logic [`FE_TID_W-1:0] cur_tid_o,
  output logic [`FE_XLEN-1:0]  cur_pc_o
);

  localparam logic [`FE_TID_W-1:0] last_tid = `FE_TID_W'(`FE_NUM_THREADS - 1);

  logic [`FE_XLEN-1:0]  pc_q    [`FE_NUM_THREADS];
  logic [`FE_XLEN-1:0]  boot_pc [`FE_NUM_THREADS];
  logic                 load_q;
  logic [`FE_TID_W-1:0] tid_q;

  // boot address of each thread
  always_comb begin
    for (int t = 0; t < `FE_NUM_THREADS; t++) begin
      boot_pc[t] = boot_addr_i + `FE_XLEN'(t) * `FE_THREAD_STRIDE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_q <= 1'b1;
      tid_q  <= '0;
    end else begin
      load_q <= 1'b0;
      if (advance_i) begin
        tid_q <= (tid_q == last_tid) ? '0 : tid_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int t = 0; t < `FE_NUM_THREADS; t++) begin
      if (write_i && write_tid_i == `FE_TID_W'(t)) begin
        pc_q[t] <= write_pc_i;
      end else if (load_q) begin
        pc_q[t] <= boot_pc[t];
      end
    end
  end

  assign cur_tid_o = tid_q;
  assign cur_pc_o  = load_q ? boot_pc[tid_q] : pc_q[tid_q];

  // writers must name an existing thread
  a_write_tid_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    write_i |-> int'(write_tid_i) < `FE_NUM_THREADS);

endmodule

// ==== design/fetch_pkg.sv ====
// types exchanged between fetch, the predictor and the backend
// only uncompressed RV32 instructions are described
// JALR is recognised but never predicted
package fetch_pkg;

  `include "fetch_macros.svh"

  // control-flow class of a fetched instruction
  typedef enum logic [1:0] {
    NoCF,
    Branch,
    Jump,
    JumpR
  } cf_e;

  // source of an external redirect
  typedef enum logic {
    RedirRet,
    RedirTrap
  } redir_kind_e;

  // decoded view of one instruction word
  typedef struct packed {
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic [`FE_XLEN-1:0] imm;
  } scan_t;

  // one entry handed to decode
  typedef struct packed {
    logic [`FE_XLEN-1:0]  pc;
    logic [`FE_XLEN-1:0]  instr;
    logic [`FE_TID_W-1:0] thread_id;
    cf_e                  cf;
    logic                 predict_taken;
    logic [`FE_XLEN-1:0]  predict_target;
    logic                 fault;
  } fetch_entry_t;

  // branch outcome from execute
  typedef struct packed {
    logic                 valid;
    logic [`FE_TID_W-1:0] thread_id;
    logic [`FE_XLEN-1:0]  pc;
    logic                 is_branch;
    logic                 taken;
    logic                 mispredict;
    logic [`FE_XLEN-1:0]  target;
  } resolve_t;

  // exception entry or return for one thread
  typedef struct packed {
    logic                 valid;
    redir_kind_e          kind;
    logic [`FE_TID_W-1:0] thread_id;
    logic [`FE_XLEN-1:0]  target;
  } redirect_t;

  // history table write port
  typedef struct packed {
    logic                valid;
    logic [`FE_XLEN-1:0] pc;
    logic                taken;
  } bht_update_t;

endpackage

// ==== design/wb_pkg.sv ====
// Wishbone classic types for a read-only instruction master
// no write enable or byte selects, every transfer is one 32-bit word
// adr carries the byte address of a word aligned PC
package wb_pkg;

  `include "fetch_macros.svh"

  // --------------------
  // master to slave
  // --------------------
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic [`FE_XLEN-1:0] adr;
  } wb_req_t;

  // --------------------
  // slave to master
  // --------------------
  typedef struct packed {
    logic                ack;
    logic                err;
    logic [`FE_XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== design/fetch_macros.svh ====
// shared sizes for the two-thread fetch frontend
// FE_TID_W must hold FE_NUM_THREADS - 1
// FE_BHT_ENTRIES and FE_QUEUE_DEPTH are expected to be powers of two
// the history table is indexed from PC bit 2 upwards
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and instruction width
`define FE_XLEN 32

// hardware threads and the width of a thread id
`define FE_NUM_THREADS 2
`define FE_TID_W 1

// predictor and queue sizes
`define FE_BHT_ENTRIES 16
`define FE_QUEUE_DEPTH 4

// thread t boots at boot_addr_i + t * stride
`define FE_THREAD_STRIDE 32'h0000_0100

`endif
